/* exec_unit.f */
cpu_pkg.sv
program_counter.sv
register_file.sv
alu.sv
cpu_sequencer.sv
exec_unit.sv
exec_unit_assertions.sv
exec_unit_tb.sv

/* exec_unit_tb.sv */
`default_nettype none

module exec_unit_tb import cpu_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ns;

    localparam int    NUM_TESTS     = 6;
    localparam int    MAX_INSTR     = 16;
    localparam int    MAX_WRITES    = 4;
    localparam int    RESET_CYCLES  = 16;
    localparam int    MARGIN_CYCLES = 40;
    localparam addr_t START_ADDR    = 16'h0000;
    localparam addr_t END_ADDR      = 16'hffff;

    logic     clk;
    logic     reset_n;
    mem_req_t mem_req;
    word_t    mem_rd_data;

    word_t    memory [65536];
    instr_t   prog [NUM_TESTS][MAX_INSTR];
    int       n_instr [NUM_TESTS];
    int       loops [NUM_TESTS];
    addr_t    exp_addr [NUM_TESTS][MAX_WRITES];
    word_t    exp_data [NUM_TESTS][MAX_WRITES];
    int       n_writes [NUM_TESTS];
    logic     preload_en [NUM_TESTS];
    addr_t    preload_addr [NUM_TESTS];
    word_t    preload_data [NUM_TESTS];
    // Low byte fetch of one instruction and the read that must follow it
    addr_t    fetch_prev [NUM_TESTS];
    addr_t    fetch_next [NUM_TESTS];

    mem_req_t write_log [$];
    addr_t    read_log [$];
    logic     read_pending;
    addr_t    read_addr;
    logic     end_seen;
    int       budget_cycles;

    exec_unit #(
        .START_ADDR (START_ADDR)
    ) exec_unit_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .mem_req     (mem_req),
        .mem_rd_data (mem_rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_on_error();
        $display("Checks failed");
        $fatal(1);
    endtask

    function automatic instr_t encode(logic [3:0] op, reg_idx_t dst, word_t low);
        return {op, dst, low};
    endfunction

    task automatic put(int t, instr_t instr);
        prog[t][n_instr[t]] = instr;
        n_instr[t]++;
    endtask

    task automatic expect_write(int t, addr_t addr, word_t data);
        exp_addr[t][n_writes[t]] = addr;
        exp_data[t][n_writes[t]] = data;
        n_writes[t]++;
    endtask

    task automatic build_table();
        word_t a;
        word_t b;
        word_t c;
        word_t sum1;
        word_t sum2;
        a = word_t'($urandom);
        b = word_t'($urandom);
        c = word_t'($urandom);
        sum1 = word_t'(a + b);
        sum2 = word_t'(sum1 - c);
        for (int t = 0; t < NUM_TESTS; t++) begin
            n_instr[t] = 0;
            n_writes[t] = 0;
            loops[t] = 1;
            preload_en[t] = 1'b0;
            fetch_prev[t] = START_ADDR + 1;
            fetch_next[t] = START_ADDR + 2;
        end
        // movi then store through the page register
        put(0, encode(op_movi, 4'd15, 8'h80));
        put(0, encode(op_movi, 4'd3, 8'h5a));
        put(0, encode(op_movi, 4'd4, 8'h10));
        put(0, encode(op_store, 4'd3, 8'h04));
        expect_write(0, 16'h8010, 8'h5a);
        // Register add and sub that both wrap
        put(1, encode(op_movi, 4'd15, 8'h80));
        put(1, encode(op_movi, 4'd1, 8'hc8));
        put(1, encode(op_movi, 4'd2, 8'h64));
        put(1, encode(op_add, 4'd3, 8'h12));
        put(1, encode(op_store, 4'd3, 8'h00));
        put(1, encode(op_sub, 4'd4, 8'h21));
        put(1, encode(op_store, 4'd4, 8'h02));
        expect_write(1, 16'h8000, 8'h2c);
        expect_write(1, 16'h8064, 8'h9c);
        // Random immediates where the last subi lands on zero
        put(2, encode(op_movi, 4'd15, 8'h81));
        put(2, encode(op_movi, 4'd1, a));
        put(2, encode(op_addi, 4'd1, b));
        put(2, encode(op_store, 4'd1, 8'h00));
        put(2, encode(op_subi, 4'd1, c));
        put(2, encode(op_store, 4'd1, 8'h01));
        put(2, encode(op_subi, 4'd1, sum2));
        put(2, encode(op_store, 4'd1, 8'h0f));
        expect_write(2, 16'h8100, sum1);
        expect_write(2, {8'h81, sum2}, sum2);
        expect_write(2, 16'h8181, 8'h00);
        // Load copy that ignores bits 7 to 4 of the load
        preload_en[3] = 1'b1;
        preload_addr[3] = 16'h8233;
        preload_data[3] = word_t'($urandom);
        put(3, encode(op_movi, 4'd15, 8'h82));
        put(3, encode(op_movi, 4'd1, 8'h33));
        put(3, encode(op_load, 4'd2, 8'h51));
        put(3, encode(op_store, 4'd2, 8'h0f));
        expect_write(3, 16'h8282, preload_data[3]);
        // Countdown from 5 with jnz at address 8 back to 4
        put(4, encode(op_movi, 4'd15, 8'h83));
        put(4, encode(op_movi, 4'd1, 8'h05));
        put(4, encode(op_addi, 4'd2, 8'h01));
        put(4, encode(op_subi, 4'd1, 8'h01));
        put(4, encode(op_jnz, 4'd0, 8'h04));
        put(4, encode(op_store, 4'd2, 8'h00));
        put(4, encode(op_store, 4'd1, 8'h02));
        expect_write(4, 16'h8300, 8'h05);
        expect_write(4, 16'h8305, 8'h00);
        loops[4] = 5;
        fetch_prev[4] = 16'h0009;
        fetch_next[4] = 16'h0004;
        // Undefined opcodes naming r1 leave it alone
        put(5, encode(op_movi, 4'd15, 8'h84));
        put(5, encode(op_movi, 4'd1, 8'h77));
        put(5, 16'h1100);
        put(5, 16'ha1ff);
        put(5, encode(op_store, 4'd1, 8'h00));
        expect_write(5, 16'h8400, 8'h77);
        fetch_prev[5] = 16'h0005;
        fetch_next[5] = 16'h0006;
        for (int t = 0; t < NUM_TESTS; t++) begin
            put(t, encode(op_movi, 4'd15, 8'hff));
            put(t, encode(op_movi, 4'd14, 8'hff));
            put(t, encode(op_store, 4'd0, 8'h0e));
            budget_cycles += RESET_CYCLES + 5 * n_instr[t] * loops[t] + MARGIN_CYCLES;
        end
    endtask

    task automatic load_memory(int t);
        for (int i = 0; i < 65536; i++) begin
            memory[i] = word_t'($urandom);
        end
        for (int i = 0; i < n_instr[t]; i++) begin
            memory[START_ADDR + INSTR_BYTES * i] = prog[t][i][15:8];
            memory[START_ADDR + INSTR_BYTES * i + 1] = prog[t][i][7:0];
        end
        if (preload_en[t]) begin
            memory[preload_addr[t]] = preload_data[t];
        end
    endtask

    task automatic check_write(int t, mem_req_t got, addr_t want_addr, word_t want_data);
        if (got.addr !== want_addr) begin
            $display("Fail mem_req.addr: test %0d got %h expected %h", t, got.addr, want_addr);
            stop_on_error();
        end
        if (got.wr_data !== want_data) begin
            $display("Fail mem_req.wr_data: test %0d got %h expected %h",
                     t, got.wr_data, want_data);
            stop_on_error();
        end
    endtask

    task automatic check_fetch(int t, addr_t got, addr_t want);
        if (got !== want) begin
            $display("Fail mem_req.addr (fetch): test %0d got %h expected %h", t, got, want);
            stop_on_error();
        end
    endtask

    task automatic check_results(int t);
        int idx;
        idx = -1;
        if (write_log.size() != n_writes[t]) begin
            $display("Test %0d made %0d memory writes before the end marker, expected %0d",
                     t, write_log.size(), n_writes[t]);
            stop_on_error();
        end
        for (int k = 0; k < n_writes[t]; k++) begin
            check_write(t, write_log[k], exp_addr[t][k], exp_data[t][k]);
        end
        for (int i = 0; i + 1 < read_log.size(); i++) begin
            if (idx < 0 && read_log[i] == fetch_prev[t]) begin
                idx = i;
            end
        end
        if (idx < 0) begin
            $display("Test %0d never fetched address %h", t, fetch_prev[t]);
            stop_on_error();
        end
        check_fetch(t, read_log[0], START_ADDR);
        check_fetch(t, read_log[1], START_ADDR + 1);
        check_fetch(t, read_log[idx + 1], fetch_next[t]);
    endtask

    // Byte memory with read data one cycle after the request and driven on the falling edge
    always @(negedge clk) begin
        if (read_pending) begin
            mem_rd_data = memory[read_addr];
        end
        read_pending = mem_req.rd_en;
        read_addr = mem_req.addr;
        if (mem_req.rd_en) begin
            read_log.push_back(mem_req.addr);
        end
        if (mem_req.wr_en) begin
            memory[mem_req.addr] = mem_req.wr_data;
            if (mem_req.addr == END_ADDR) begin
                end_seen = 1'b1;
            end else begin
                write_log.push_back(mem_req);
            end
        end
    end

    always @(negedge clk) begin
        if (exec_unit_i.assertions_i.error_count != 0) begin
            $display("A bound assertion on the memory port or stage order failed");
            stop_on_error();
        end
    end

    initial begin : watchdog
        wait (budget_cycles > 0);
        repeat (budget_cycles) @(posedge clk);
        $display("Timeout: programs did not reach the end marker in %0d cycles", budget_cycles);
        stop_on_error();
    end

    initial begin
        void'($urandom(32'hcf6b_1cfe));
        reset_n = 1'b0;
        mem_rd_data = '0;
        read_pending = 1'b0;
        read_addr = '0;
        end_seen = 1'b0;
        budget_cycles = 0;
        build_table();
        for (int t = 0; t < NUM_TESTS; t++) begin
            @(negedge clk);
            reset_n = 1'b0;
            // Strobes stay low from here on so memory and logs can be cleared
            @(negedge clk);
            load_memory(t);
            write_log.delete();
            read_log.delete();
            end_seen = 1'b0;
            repeat (RESET_CYCLES - 1) @(negedge clk);
            reset_n = 1'b1;
            while (!end_seen) @(posedge clk);
            check_results(t);
        end
        // Lets assertions on the last edge finish their action blocks
        @(negedge clk);
        if (exec_unit_i.assertions_i.error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* exec_unit_assertions.sv */
`default_nettype none

module exec_unit_assertions import cpu_pkg::*; #(
    parameter addr_t START_ADDR = '0
) (
    input logic     clk,
    input logic     reset_n,
    input mem_req_t mem_req,
    input stage_e   stage,
    input logic     pc_advance,
    input logic     pc_jump
);

    timeunit 1ns;
    timeprecision 1ns;

    int unsigned error_count = 0;

    task automatic note_failure(string what);
        error_count++;
        $error("%s", what);
    endtask

    property step(stage_e from, stage_e to);
        @(posedge clk) disable iff (!reset_n) stage == from |=> stage == to;
    endproperty

    // A single memory port allows a read or a write per cycle but never both
    strobes_exclusive: assert property (@(posedge clk) disable iff (!reset_n)
        !(mem_req.rd_en && mem_req.wr_en)) else note_failure("rd_en and wr_en high together");

    write_one_cycle: assert property (@(posedge clk) disable iff (!reset_n)
        mem_req.wr_en |=> !mem_req.wr_en) else note_failure("wr_en held for two cycles");

    first_read: assert property (@(posedge clk)
        $rose(reset_n) |=> mem_req.rd_en && !mem_req.wr_en && mem_req.addr == START_ADDR)
        else note_failure("first request after reset is not a read of the start address");

    pc_strobes: assert property (@(posedge clk) disable iff (!reset_n)
        !(pc_advance && pc_jump)) else note_failure("pc_advance and pc_jump high together");

    hi_to_lo: assert property (@(posedge clk) disable iff (!reset_n)
        stage == fetch_hi && mem_req.rd_en |=> stage == fetch_lo)
        else note_failure("fetch_hi read not followed by fetch_lo");

    lo_to_decode: assert property (step(fetch_lo, decode))
        else note_failure("bad stage after fetch_lo");
    decode_to_exec: assert property (step(decode, execute))
        else note_failure("bad stage after decode");
    wb_to_fetch: assert property (step(load_wb, fetch_hi))
        else note_failure("bad stage after load_wb");

    exec_to_next: assert property (@(posedge clk) disable iff (!reset_n)
        stage == execute |=> stage inside {fetch_hi, load_wb})
        else note_failure("bad stage after execute");

endmodule

bind exec_unit exec_unit_assertions #(
    .START_ADDR (START_ADDR)
) assertions_i (
    .clk        (clk),
    .reset_n    (reset_n),
    .mem_req    (mem_req),
    .stage      (sequencer_i.stage),
    .pc_advance (pc_advance),
    .pc_jump    (pc_jump)
);

`default_nettype wire

/* exec_unit.sv */
`default_nettype none

module exec_unit import cpu_pkg::*; #(
    parameter addr_t START_ADDR = '0
) (
    input  logic     clk,
    input  logic     reset_n,
    output mem_req_t mem_req,
    input  word_t    mem_rd_data
);

    addr_t    pc;
    addr_t    jump_target;
    logic     pc_advance;
    logic     pc_jump;
    dp_ctrl_t dp_ctrl;
    word_t    rd0_data;
    word_t    rd1_data;
    word_t    alu_result;
    word_t    load_data;
    logic     zero_flag;

    cpu_sequencer sequencer_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .pc          (pc),
        .mem_rd_data (mem_rd_data),
        .rd0_data    (rd0_data),
        .rd1_data    (rd1_data),
        .zero_flag   (zero_flag),
        .mem_req     (mem_req),
        .dp_ctrl     (dp_ctrl),
        .load_data   (load_data),
        .pc_advance  (pc_advance),
        .pc_jump     (pc_jump),
        .jump_target (jump_target)
    );

    program_counter #(
        .START_ADDR (START_ADDR)
    ) pc_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .pc_advance  (pc_advance),
        .pc_jump     (pc_jump),
        .jump_target (jump_target),
        .pc          (pc)
    );

    register_file regs_i (
        .clk        (clk),
        .reset_n    (reset_n),
        .dp_ctrl    (dp_ctrl),
        .alu_result (alu_result),
        .load_data  (load_data),
        .rd0_data   (rd0_data),
        .rd1_data   (rd1_data)
    );

    alu alu_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .dp_ctrl   (dp_ctrl),
        .a         (rd0_data),
        .b_reg     (rd1_data),
        .result    (alu_result),
        .zero_flag (zero_flag)
    );

endmodule

`default_nettype wire

/* cpu_sequencer.sv */
`default_nettype none

module cpu_sequencer import cpu_pkg::*; (
    input  logic     clk,
    input  logic     reset_n,
    input  addr_t    pc,
    input  word_t    mem_rd_data,
    input  word_t    rd0_data,
    input  word_t    rd1_data,
    input  logic     zero_flag,
    output mem_req_t mem_req,
    output dp_ctrl_t dp_ctrl,
    output word_t    load_data,
    output logic     pc_advance,
    output logic     pc_jump,
    output addr_t    jump_target
);

    // High address byte of every load and store
    localparam reg_idx_t PAGE_REG = 4'd15;

    stage_e   stage;
    instr_t   ir;
    opcode_e  opcode;
    reg_idx_t dst_idx;
    reg_idx_t hi_idx;
    reg_idx_t lo_idx;
    word_t    page_q;
    logic     rd_en_q;
    logic     wr_en_q;
    logic     is_load;
    logic     is_store;

    assign opcode   = opcode_e'(ir[15:12]);
    assign dst_idx  = ir[11:8];
    assign hi_idx   = ir[7:4];
    assign lo_idx   = ir[3:0];
    assign is_load  = (opcode == op_load);
    assign is_store = (opcode == op_store);

    // Strobes are registered one stage ahead so they stay low while in reset
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            stage   <= fetch_hi;
            rd_en_q <= 1'b0;
            wr_en_q <= 1'b0;
        end else begin
            case (stage)
                fetch_hi: begin
                    // Waits here once after reset until the first read is out
                    if (rd_en_q) begin
                        stage <= fetch_lo;
                    end
                    rd_en_q <= 1'b1;
                end
                fetch_lo: begin
                    stage   <= decode;
                    rd_en_q <= 1'b0;
                end
                decode: begin
                    stage   <= execute;
                    rd_en_q <= is_load;
                    wr_en_q <= is_store;
                end
                execute: begin
                    stage   <= is_load ? load_wb : fetch_hi;
                    rd_en_q <= !is_load;
                    wr_en_q <= 1'b0;
                end
                load_wb: begin
                    stage   <= fetch_hi;
                    rd_en_q <= 1'b1;
                end
                default: begin
                    stage   <= fetch_hi;
                    rd_en_q <= 1'b0;
                    wr_en_q <= 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (stage == fetch_lo) begin
            ir[15:8] <= mem_rd_data;
        end
        if (stage == decode) begin
            ir[7:0] <= mem_rd_data;
            page_q  <= rd1_data;
        end
    end

    always_comb begin
        dp_ctrl        = '0;
        dp_ctrl.imm    = ir[7:0];
        dp_ctrl.wr_idx = dst_idx;
        dp_ctrl.wr_src = src_alu;
        pc_advance     = 1'b0;
        pc_jump        = 1'b0;
        case (stage)
            decode: dp_ctrl.rd1_idx = PAGE_REG;
            execute: begin
                pc_advance = 1'b1;
                case (opcode)
                    op_movi: begin
                        dp_ctrl.wr_en  = 1'b1;
                        dp_ctrl.wr_src = src_imm;
                    end
                    op_add, op_sub: begin
                        dp_ctrl.rd0_idx     = hi_idx;
                        dp_ctrl.rd1_idx     = lo_idx;
                        dp_ctrl.wr_en       = 1'b1;
                        dp_ctrl.subtract    = (opcode == op_sub);
                        dp_ctrl.update_flag = 1'b1;
                    end
                    op_addi, op_subi: begin
                        dp_ctrl.rd0_idx     = dst_idx;
                        dp_ctrl.use_imm     = 1'b1;
                        dp_ctrl.wr_en       = 1'b1;
                        dp_ctrl.subtract    = (opcode == op_subi);
                        dp_ctrl.update_flag = 1'b1;
                    end
                    op_load, op_store: begin
                        // Port 0 gives store data, port 1 the low address byte
                        dp_ctrl.rd0_idx = dst_idx;
                        dp_ctrl.rd1_idx = lo_idx;
                    end
                    op_jnz: begin
                        if (!zero_flag) begin
                            pc_jump    = 1'b1;
                            pc_advance = 1'b0;
                        end
                    end
                    // nop and undefined opcodes only advance
                    default: ;
                endcase
            end
            load_wb: begin
                dp_ctrl.wr_en  = 1'b1;
                dp_ctrl.wr_src = src_mem;
            end
            default: ;
        endcase
    end

    always_comb begin
        mem_req.rd_en   = rd_en_q;
        mem_req.wr_en   = wr_en_q;
        mem_req.wr_data = rd0_data;
        case (stage)
            fetch_lo: mem_req.addr = pc + addr_t'(1);
            execute:  mem_req.addr = {page_q, rd1_data};
            default:  mem_req.addr = pc;
        endcase
    end

    // Read data is valid during load_wb and written at its end
    assign load_data   = mem_rd_data;
    assign jump_target = {8'h00, ir[7:0]};

endmodule

`default_nettype wire

/* alu.sv */
`default_nettype none

module alu import cpu_pkg::*; (
    input  logic     clk,
    input  logic     reset_n,
    input  dp_ctrl_t dp_ctrl,
    input  word_t    a,
    input  word_t    b_reg,
    output word_t    result,
    output logic     zero_flag
);

    word_t b;

    assign b = dp_ctrl.use_imm ? dp_ctrl.imm : b_reg;

    // Wraps modulo 256, no carry is kept
    always_comb begin
        if (dp_ctrl.subtract) begin
            result = a - b;
        end else begin
            result = a + b;
        end
    end

    // Updated on the same edge that writes the result back
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            zero_flag <= 1'b0;
        end else if (dp_ctrl.update_flag) begin
            zero_flag <= (result == '0);
        end
    end

endmodule

`default_nettype wire

/* register_file.sv */
`default_nettype none

module register_file import cpu_pkg::*; (
    input  logic     clk,
    input  logic     reset_n,
    input  dp_ctrl_t dp_ctrl,
    input  word_t    alu_result,
    input  word_t    load_data,
    output word_t    rd0_data,
    output word_t    rd1_data
);

    localparam int unsigned NUM_REGS = 16;

    word_t regs [NUM_REGS];
    word_t wr_data;

    always_comb begin
        case (dp_ctrl.wr_src)
            src_imm: wr_data = dp_ctrl.imm;
            src_mem: wr_data = load_data;
            default: wr_data = alu_result;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (dp_ctrl.wr_en) begin
            regs[dp_ctrl.wr_idx] <= wr_data;
        end
    end

    // Reads are combinational, a write shows up the cycle after
    assign rd0_data = regs[dp_ctrl.rd0_idx];
    assign rd1_data = regs[dp_ctrl.rd1_idx];

endmodule

`default_nettype wire

/* program_counter.sv */
`default_nettype none

module program_counter import cpu_pkg::*; #(
    parameter addr_t START_ADDR = '0
) (
    input  logic  clk,
    input  logic  reset_n,
    input  logic  pc_advance,
    input  logic  pc_jump,
    input  addr_t jump_target,
    output addr_t pc
);

    addr_t next_pc;

    // Jump wins, though the sequencer never raises both
    always_comb begin
        if (pc_jump) begin
            next_pc = jump_target;
        end else if (pc_advance) begin
            next_pc = pc + addr_t'(INSTR_BYTES);
        end else begin
            next_pc = pc;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            pc <= START_ADDR;
        end else begin
            pc <= next_pc;
        end
    end

endmodule

`default_nettype wire

/* cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    localparam int unsigned INSTR_BYTES = 2;

    typedef logic [7:0]  word_t;
    typedef logic [15:0] addr_t;
    typedef logic [3:0]  reg_idx_t;

    // [15:12] opcode, [11:8] destination, [7:0] immediate or {hi reg, lo reg}
    typedef logic [15:0] instr_t;

    typedef enum logic [3:0] {
        op_movi  = 4'd0,
        op_load  = 4'd2,
        op_store = 4'd3,
        op_add   = 4'd4,
        op_addi  = 4'd5,
        op_sub   = 4'd6,
        op_subi  = 4'd7,
        op_jnz   = 4'd8,
        op_nop   = 4'd15
    } opcode_e;

    typedef enum logic [2:0] {
        fetch_hi,
        fetch_lo,
        decode,
        execute,
        load_wb
    } stage_e;

    typedef enum logic [1:0] {
        src_alu,
        src_imm,
        src_mem
    } wr_src_e;

    typedef struct packed {
        logic  rd_en;
        logic  wr_en;
        addr_t addr;
        word_t wr_data;
    } mem_req_t;

    typedef struct packed {
        reg_idx_t rd0_idx;
        reg_idx_t rd1_idx;
        reg_idx_t wr_idx;
        logic     wr_en;
        wr_src_e  wr_src;
        word_t    imm;
        logic     use_imm;
        logic     subtract;
        logic     update_flag;
    } dp_ctrl_t;

endpackage

`default_nettype wire
